// ==== all.f ====
+incdir+common
common/rename_pkg.sv
common/wb_if.sv
rat/rat_array.sv
rat/rat.sv
rob/rob.sv
verilog/rename_core.sv
testbench/rename_core_chk.sv
testbench/rename_core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = rename_core_tb
FILELIST  = all.f
LOG       = sim.log
PASS_MSG  = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== testbench/rename_core_tb.sv ====
// Rename core testbench
`timescale 1ns/1ns
`include "rename_defs.svh"

module rename_core_tb import rename_pkg::*; ();
  logic clk = 1'b0;
  logic rst, rename_valid, wb_valid, wb_error;
  dest_reg_t rename_rd;
  arch_reg_t rename_rs1, rename_rs2;
  rob_tag_t wb_tag;
  word_t wb_result;
  logic rob_full, rs1_valid, rs2_valid, retire_valid, flush, exception_valid;
  word_t rs1_tagval, rs2_tagval, retire_result;
  dest_reg_t retire_rd;
  rob_tag_t exception_tag;
  int unsigned rng_state = 53;
  int val_errors = 0;
  int other_errors = 0;
  int cycles = 0;
  // Reference model state
  logic ent_done [`RENAME_ROB_DEPTH];
  logic ent_err [`RENAME_ROB_DEPTH];
  word_t ent_res [`RENAME_ROB_DEPTH];
  dest_reg_t ent_dest [`RENAME_ROB_DEPTH];
  rob_tag_t order_q [$];
  rob_tag_t next_tag;
  word_t arch_val [`RENAME_NREGS];
  word_t reg_val [`RENAME_NREGS];
  logic prod_valid [`RENAME_NREGS];
  rob_tag_t prod_tag [`RENAME_NREGS];
  logic err_phase;
  // Operand expectations, one stage per clock
  logic nxt_due = 1'b0;
  logic cur_due = 1'b0;
  logic [32:0] nxt_exp1, nxt_exp2, cur_exp1, cur_exp2;

  rename_core u_dut (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= 4000) begin
      $display("Timeout, run stopped after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic int unsigned next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state >> 16;
  endfunction

  // Expected {valid, value or tag} of a source
  function automatic logic [32:0] expect_operand(logic pend, rob_tag_t tag, word_t val);
    if (!pend) return {1'b1, val};
    if (ent_done[tag] && !ent_err[tag]) return {1'b1, ent_res[tag]};
    return {1'b0, word_t'(tag)};
  endfunction

  function automatic logic [32:0] source_snapshot(arch_reg_t r);
    if (prod_valid[r]) return expect_operand(1'b1, prod_tag[r], '0);
    return {1'b1, reg_val[r]};
  endfunction

  task automatic log_mismatch(string name, logic [63:0] exp, logic [63:0] act);
    val_errors++;
    $display("FAILED %s expected %h actual %h", name, exp, act);
  endtask

  task automatic step_clear();
    @(posedge clk);
    #1;
    rename_valid = 1'b0;
    wb_valid = 1'b0;
    wb_error = 1'b0;
  endtask

  task automatic do_rename(dest_reg_t rd, arch_reg_t rs1, arch_reg_t rs2);
    rename_valid = 1'b1;
    rename_rd = rd;
    rename_rs1 = rs1;
    rename_rs2 = rs2;
    // Sources see the old producer, before this dest lands
    nxt_exp1 = source_snapshot(rs1);
    nxt_exp2 = source_snapshot(rs2);
    nxt_due = 1'b1;
    ent_done[next_tag] = 1'b0;
    ent_err[next_tag] = 1'b0;
    ent_dest[next_tag] = rd;
    order_q.push_back(next_tag);
    if (!rd.no_dest) begin
      prod_valid[rd.areg] = 1'b1;
      prod_tag[rd.areg] = next_tag;
    end
    next_tag++;
  endtask

  // err_mode 0 clean, 1 rare error, 2 forced error
  task automatic do_writeback(int err_mode);
    rob_tag_t cand [$];
    rob_tag_t t;
    foreach (order_q[i]) if (!ent_done[order_q[i]]) cand.push_back(order_q[i]);
    if (cand.size() == 0) return;
    t = cand[next_rand() % cand.size()];
    wb_valid = 1'b1;
    wb_tag = t;
    wb_result = next_rand() ^ (next_rand() << 16);
    wb_error = (err_mode == 2) || (err_mode == 1 && next_rand() % 32 == 0);
    if (wb_error) err_phase = 1'b1;
    ent_done[t] = 1'b1;
    ent_err[t] = wb_error;
    ent_res[t] = wb_result;
  endtask

  // Clean result for the oldest entry, so the head can retire
  task automatic write_back_head();
    rob_tag_t t;
    t = order_q[0];
    wb_valid = 1'b1;
    wb_tag = t;
    wb_error = 1'b0;
    wb_result = next_rand() ^ (next_rand() << 16);
    ent_done[t] = 1'b1;
    ent_err[t] = 1'b0;
    ent_res[t] = wb_result;
  endtask

  task automatic random_cycle(int err_mode);
    dest_reg_t rd;
    step_clear();
    if (flush) return;
    if (next_rand() % 2 == 0) do_writeback(err_mode);
    // Model frees a slot only once it has seen the retire pulse
    if (!rob_full && order_q.size() < `RENAME_ROB_DEPTH && !err_phase &&
        next_rand() % 2 == 0) begin
      rd.no_dest = (next_rand() % 8 == 0);
      rd.areg = arch_reg_t'(next_rand() % 8);
      do_rename(rd, arch_reg_t'(next_rand() % 8), arch_reg_t'(next_rand() % 8));
    end
  endtask

  task automatic drain();
    while (order_q.size() > 0) begin
      step_clear();
      if (!flush) do_writeback(0);
    end
  endtask

  // Read every register once through no-dest renames
  task automatic read_all();
    for (int i = 0; i < `RENAME_NREGS / 2; i++) begin
      step_clear();
      do_rename({1'b1, 5'd0}, arch_reg_t'(2 * i), arch_reg_t'(2 * i + 1));
    end
  endtask

  // Compare process, outputs are settled at the falling edge
  always @(negedge clk) begin
    rob_tag_t f;
    if (!rst) begin
      if (cur_due) begin
        cur_exp1 = expect_operand(!cur_exp1[32], cur_exp1[3:0], cur_exp1[31:0]);
        cur_exp2 = expect_operand(!cur_exp2[32], cur_exp2[3:0], cur_exp2[31:0]);
        assert ({rs1_valid, rs1_tagval} == cur_exp1)
          else log_mismatch("rs1 operand", 64'(cur_exp1), 64'({rs1_valid, rs1_tagval}));
        assert ({rs2_valid, rs2_tagval} == cur_exp2)
          else log_mismatch("rs2 operand", 64'(cur_exp2), 64'({rs2_valid, rs2_tagval}));
      end
      cur_due = nxt_due;
      cur_exp1 = nxt_exp1;
      cur_exp2 = nxt_exp2;
      nxt_due = 1'b0;
      // Exception pulse only together with the flush
      assert (exception_valid == flush) else begin
        other_errors++;
        $display("exception_valid and flush disagree");
      end
      if ((retire_valid || flush) && order_q.size() == 0) begin
        other_errors++;
        $display("Retire or flush seen with no entry outstanding");
      end else if (retire_valid) begin
        f = order_q.pop_front();
        assert (ent_done[f] && !ent_err[f]) else begin
          other_errors++;
          $display("Entry %0d retired before a clean writeback", f);
        end
        assert (retire_rd == ent_dest[f])
          else log_mismatch("retire rd", 64'(ent_dest[f]), 64'(retire_rd));
        assert (retire_result == ent_res[f])
          else log_mismatch("retire result", 64'(ent_res[f]), 64'(retire_result));
        if (!ent_dest[f].no_dest) begin
          arch_val[ent_dest[f].areg] = ent_res[f];
          if (prod_valid[ent_dest[f].areg] && prod_tag[ent_dest[f].areg] == f) begin
            prod_valid[ent_dest[f].areg] = 1'b0;
            reg_val[ent_dest[f].areg] = ent_res[f];
          end
        end
      end else if (flush) begin
        f = order_q[0];
        assert (ent_err[f] && exception_valid) else begin
          other_errors++;
          $display("Flush without an error entry at the head");
        end
        assert (exception_tag == f)
          else log_mismatch("exception tag", 64'(f), 64'(exception_tag));
        // Speculative state is gone, committed values remain
        order_q.delete();
        next_tag = '0;
        err_phase = 1'b0;
        for (int i = 0; i < `RENAME_NREGS; i++) begin
          prod_valid[i] = 1'b0;
          reg_val[i] = arch_val[i];
        end
      end
    end
  end

  initial begin
    rst = 1'b1;
    rename_valid = 1'b0;
    rename_rd = '0;
    rename_rs1 = '0;
    rename_rs2 = '0;
    wb_valid = 1'b0;
    wb_error = 1'b0;
    wb_tag = '0;
    wb_result = '0;
    next_tag = '0;
    err_phase = 1'b0;
    for (int i = 0; i < `RENAME_NREGS; i++) begin
      arch_val[i] = '0;
      reg_val[i] = '0;
      prod_valid[i] = 1'b0;
      prod_tag[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    // Reset values, which also fills the ROB
    read_all();
    step_clear();
    assert (rob_full) else begin
      other_errors++;
      $display("rob_full stayed low with every entry allocated");
    end
    write_back_head();
    while (order_q.size() == `RENAME_ROB_DEPTH) step_clear();
    assert (!rob_full) else begin
      other_errors++;
      $display("rob_full stayed high after a retirement");
    end
    drain();
    // Dependent traffic with out-of-order writebacks
    repeat (1200) random_cycle(0);
    drain();
    read_all();
    drain();
    // Error at the head, then committed values only
    for (int r = 0; r < 4; r++) begin
      repeat (100) random_cycle(1);
      step_clear();
      if (!flush) do_writeback(2);
      drain();
      read_all();
      drain();
    end
    repeat (4) step_clear();
    $display("Errors: %0d value mismatches, %0d other failures", val_errors, other_errors);
    if (val_errors == 0 && other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end
endmodule

// ==== testbench/rename_core_chk.sv ====
// Rename core control checks
`timescale 1ns/1ns

module rename_core_chk (
  input logic clk,
  input logic rst,
  input logic rename_valid,
  input logic rob_full,
  input logic retire_valid,
  input logic flush
);
  // Decode must hold off while the ROB is full
  assert property (@(posedge clk) disable iff (rst) rename_valid |-> !rob_full)
    else $error("rename issued while rob_full was high");

  // A head entry either retires or flushes
  assert property (@(posedge clk) disable iff (rst) !(retire_valid && flush))
    else $error("retire_valid and flush high together");

  // Clean state right out of reset
  assert property (@(posedge clk) $fell(rst) |-> (!rob_full && !flush))
    else $error("rob_full or flush high after reset");
endmodule

bind rename_core rename_core_chk u_chk (
  .clk, .rst, .rename_valid, .rob_full, .retire_valid, .flush
);

// ==== verilog/rename_core.sv ====
// Register rename core
`timescale 1ns/1ns

module rename_core import rename_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  // Rename request from decode
  input  logic      rename_valid,
  input  dest_reg_t rename_rd,
  input  arch_reg_t rename_rs1,
  input  arch_reg_t rename_rs2,
  output logic      rob_full,
  // Operands, one clock after rename
  output logic      rs1_valid,
  output word_t     rs1_tagval,
  output logic      rs2_valid,
  output word_t     rs2_tagval,
  // Results from execution
  input  logic      wb_valid,
  input  logic      wb_error,
  input  rob_tag_t  wb_tag,
  input  word_t     wb_result,
  // In-order retirement
  output logic      retire_valid,
  output dest_reg_t retire_rd,
  output word_t     retire_result,
  // Error at head
  output logic      flush,
  output logic      exception_valid,
  output rob_tag_t  exception_tag
);
  rob_tag_t alloc_tag;

  // ROB to RAT writeback with destination attached
  wb_if wb_bus ();

  rob u_rob (
    .clk, .rst,
    .rename_valid, .rename_rd,
    .alloc_tag, .rob_full,
    .wb_valid, .wb_error, .wb_tag, .wb_result,
    .wb(wb_bus.master),
    .retire_valid, .retire_rd, .retire_result,
    .flush, .exception_valid, .exception_tag
  );

  rat u_rat (
    .clk, .rst,
    .rename_valid, .rename_rd, .rename_rs1, .rename_rs2,
    .alloc_tag,
    .wb(wb_bus.rat),
    .retire_valid, .retire_rd, .retire_result,
    .flush,
    .rs1_valid, .rs1_tagval,
    .rs2_valid, .rs2_tagval
  );
endmodule

// ==== rob/rob.sv ====
// Reorder buffer
`timescale 1ns/1ns
`include "rename_defs.svh"

module rob import rename_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      rename_valid,
  input  dest_reg_t rename_rd,
  output rob_tag_t  alloc_tag,
  output logic      rob_full,
  input  logic      wb_valid,
  input  logic      wb_error,
  input  rob_tag_t  wb_tag,
  input  word_t     wb_result,
  wb_if.master      wb,
  output logic      retire_valid,
  output dest_reg_t retire_rd,
  output word_t     retire_result,
  output logic      flush,
  output logic      exception_valid,
  output rob_tag_t  exception_tag
);
  // Entry storage
  dest_reg_t ent_dest   [`RENAME_ROB_DEPTH];
  logic      ent_done   [`RENAME_ROB_DEPTH];
  logic      ent_err    [`RENAME_ROB_DEPTH];
  word_t     ent_result [`RENAME_ROB_DEPTH];
  // Circular buffer pointers
  rob_tag_t  head;
  rob_tag_t  tail;
  logic [`RENAME_ROB_IDX_W:0] count;
  logic      push;
  logic      pop;
  logic      accept_wb;

  // Nothing moves during the flush cycle
  assign push      = rename_valid & ~flush;
  assign accept_wb = wb_valid & ~flush;
  // Head leaves once its result is in
  assign pop       = (count != '0) & ent_done[head] & ~flush;

  // New tag is the tail slot
  assign alloc_tag = tail;
  assign rob_full  = (count == `RENAME_ROB_DEPTH);

  // Destination lookup for the RAT, same cycle
  assign wb.valid  = accept_wb;
  assign wb.error  = wb_error;
  assign wb.tag    = wb_tag;
  assign wb.dest   = ent_dest[wb_tag];
  assign wb.result = wb_result;

  // Allocate at tail, capture results by tag
  always_ff @(posedge clk) begin
    if (push) begin
      ent_dest[tail] <= rename_rd;
      ent_done[tail] <= 1'b0;
      ent_err[tail]  <= 1'b0;
    end
    if (accept_wb) begin
      ent_done[wb_tag]   <= 1'b1;
      ent_err[wb_tag]    <= wb_error;
      ent_result[wb_tag] <= wb_result;
    end
  end

  // Flush empties the buffer
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= tail + 1'b1;
      end
      if (pop) begin
        head <= head + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // One-cycle pulses after the head completes
  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid <= 1'b0;
      flush        <= 1'b0;
    end else begin
      retire_valid <= pop & ~ent_err[head];
      flush        <= pop & ent_err[head];
    end
  end

  // Retired entry payload
  always_ff @(posedge clk) begin
    if (pop) begin
      retire_rd     <= ent_dest[head];
      retire_result <= ent_result[head];
      exception_tag <= head;
    end
  end

  // Exception pulse is the flush itself
  assign exception_valid = flush;
endmodule

// ==== rat/rat.sv ====
// Register alias table
`timescale 1ns/1ns
`include "rename_defs.svh"

module rat import rename_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      rename_valid,
  input  dest_reg_t rename_rd,
  input  arch_reg_t rename_rs1,
  input  arch_reg_t rename_rs2,
  input  rob_tag_t  alloc_tag,
  wb_if.rat         wb,
  input  logic      retire_valid,
  input  dest_reg_t retire_rd,
  input  word_t     retire_result,
  input  logic      flush,
  output logic      rs1_valid,
  output word_t     rs1_tagval,
  output logic      rs2_valid,
  output word_t     rs2_tagval
);
  // Per-register state bits
  logic [`RENAME_NREGS-1:0] reg_valid;
  logic [`RENAME_NREGS-1:0] reg_committed;
  // Registered read data
  word_t     comm_rs1;
  word_t     comm_rs2;
  word_t     spec_raw1;
  word_t     spec_raw2;
  rob_tag_t  tag_rs1;
  rob_tag_t  tag_rs2;
  rob_tag_t  tag_wb;
  logic      valid_rs1;
  logic      valid_rs2;
  logic      committed_rs1;
  logic      committed_rs2;
  logic      byp_rs1;
  logic      byp_rs2;
  word_t     byp_result;
  // Previous writeback copy
  logic      prev_write;
  logic      prev_killed;
  rob_tag_t  prev_tag;
  arch_reg_t prev_dest;
  word_t     prev_result;
  logic      cur_write;
  logic      ld_tag;
  logic      ld_comm;
  logic      ld_spec;

  function automatic word_t pick_operand(
    input logic     committed,
    input logic     spec_ok,
    input logic     fwd_prev,
    input logic     fwd_cur,
    input word_t    comm_val,
    input word_t    spec_val,
    input word_t    prev_val,
    input word_t    cur_val,
    input rob_tag_t tag
  );
    if (committed) begin
      return comm_val;
    end else if (spec_ok) begin
      return spec_val;
    end else if (fwd_prev) begin
      return prev_val;
    end else if (fwd_cur) begin
      return cur_val;
    end
    // Still pending, hand back the producer tag
    return word_t'(tag);
  endfunction

  // Error results are never forwarded or written
  assign cur_write = wb.valid & ~wb.error & ~wb.dest.no_dest;
  assign ld_tag    = rename_valid & ~rename_rd.no_dest & ~flush;
  assign ld_comm   = retire_valid & ~retire_rd.no_dest;
  // Spec write only while the writer is still the newest producer
  assign ld_spec   = prev_write & ~prev_killed & (prev_tag == tag_wb);

  rat_array #(.data_t(word_t)) u_comm_array (
    .clk, .rst, .rd_en(rename_valid),
    .rd_addr1(rename_rs1), .rd_addr2(rename_rs2),
    .rd_data1(comm_rs1), .rd_data2(comm_rs2),
    .rd_addr3('0), .rd_data3(),
    .wr_en(ld_comm), .wr_addr(retire_rd.areg), .wr_data(retire_result)
  );

  // Port 3 finds the current producer of the writeback destination
  rat_array #(.data_t(rob_tag_t)) u_tag_array (
    .clk, .rst, .rd_en(rename_valid),
    .rd_addr1(rename_rs1), .rd_addr2(rename_rs2),
    .rd_data1(tag_rs1), .rd_data2(tag_rs2),
    .rd_addr3(wb.dest.areg), .rd_data3(tag_wb),
    .wr_en(ld_tag), .wr_addr(rename_rd.areg), .wr_data(alloc_tag)
  );

  rat_array #(.data_t(word_t)) u_spec_array (
    .clk, .rst, .rd_en(rename_valid),
    .rd_addr1(rename_rs1), .rd_addr2(rename_rs2),
    .rd_data1(spec_raw1), .rd_data2(spec_raw2),
    .rd_addr3('0), .rd_data3(),
    .wr_en(ld_spec), .wr_addr(prev_dest), .wr_data(prev_result)
  );

  // Flush beats rename, rename beats writeback
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      reg_valid     <= '1;
      reg_committed <= '1;
    end else begin
      if (ld_spec) begin
        reg_valid[prev_dest] <= 1'b1;
      end
      if (ld_tag) begin
        reg_valid[rename_rd.areg]     <= 1'b0;
        reg_committed[rename_rd.areg] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      prev_write <= 1'b0;
    end else begin
      prev_write <= cur_write;
    end
  end

  // Rename to the same register this cycle makes the tag lookup stale
  always_ff @(posedge clk) begin
    prev_killed <= ld_tag & (rename_rd.areg == wb.dest.areg);
    prev_tag    <= wb.tag;
    prev_dest   <= wb.dest.areg;
    prev_result <= wb.result;
  end

  // Read stage, covers the spec write that lands this same cycle
  always_ff @(posedge clk) begin
    if (rename_valid) begin
      byp_rs1       <= ld_spec & (rename_rs1 == prev_dest);
      byp_rs2       <= ld_spec & (rename_rs2 == prev_dest);
      byp_result    <= prev_result;
      valid_rs1     <= reg_valid[rename_rs1] | (ld_spec & (rename_rs1 == prev_dest));
      valid_rs2     <= reg_valid[rename_rs2] | (ld_spec & (rename_rs2 == prev_dest));
      committed_rs1 <= reg_committed[rename_rs1];
      committed_rs2 <= reg_committed[rename_rs2];
    end
  end

  // Operand select, forwarding from current and previous writeback
  always_comb begin
    logic fwd_prev1;
    logic fwd_prev2;
    logic fwd_cur1;
    logic fwd_cur2;
    fwd_prev1  = prev_write & (prev_tag == tag_rs1);
    fwd_prev2  = prev_write & (prev_tag == tag_rs2);
    fwd_cur1   = cur_write & (wb.tag == tag_rs1);
    fwd_cur2   = cur_write & (wb.tag == tag_rs2);
    rs1_valid  = committed_rs1 | valid_rs1 | fwd_prev1 | fwd_cur1;
    rs2_valid  = committed_rs2 | valid_rs2 | fwd_prev2 | fwd_cur2;
    rs1_tagval = pick_operand(committed_rs1, valid_rs1, fwd_prev1, fwd_cur1, comm_rs1,
                              byp_rs1 ? byp_result : spec_raw1, prev_result, wb.result,
                              tag_rs1);
    rs2_tagval = pick_operand(committed_rs2, valid_rs2, fwd_prev2, fwd_cur2, comm_rs2,
                              byp_rs2 ? byp_result : spec_raw2, prev_result, wb.result,
                              tag_rs2);
  end
endmodule

// ==== rat/rat_array.sv ====
// Alias table storage array
`timescale 1ns/1ns
`include "rename_defs.svh"

module rat_array import rename_pkg::*; #(
  parameter type data_t = word_t
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      rd_en,
  input  arch_reg_t rd_addr1,
  input  arch_reg_t rd_addr2,
  output data_t     rd_data1,
  output data_t     rd_data2,
  input  arch_reg_t rd_addr3,
  output data_t     rd_data3,
  input  logic      wr_en,
  input  arch_reg_t wr_addr,
  input  data_t     wr_data
);
  data_t mem [`RENAME_NREGS];

  // Synchronous write, all entries zero after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RENAME_NREGS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Rename ports sample on rd_en
  // Port 3 samples every cycle, old data on a same-cycle write
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data1 <= mem[rd_addr1];
      rd_data2 <= mem[rd_addr2];
    end
    rd_data3 <= mem[rd_addr3];
  end
endmodule

// ==== common/wb_if.sv ====
// Writeback bus
`timescale 1ns/1ns

interface wb_if import rename_pkg::*; ();
  // One result per cycle, destination already looked up by the ROB
  logic      valid;
  logic      error;
  rob_tag_t  tag;
  dest_reg_t dest;
  word_t     result;

  // ROB side
  modport master (output valid, error, tag, dest, result);

  // Alias table side
  modport rat (input valid, error, tag, dest, result);
endinterface

// ==== common/rename_pkg.sv ====
// Rename shared types
`include "rename_defs.svh"

package rename_pkg;

  // Architectural register number
  typedef logic [$clog2(`RENAME_NREGS)-1:0] arch_reg_t;

  // Data word
  typedef logic [`RENAME_XLEN-1:0] word_t;

  // ROB index, also the rename tag
  typedef logic [`RENAME_ROB_IDX_W-1:0] rob_tag_t;

  // Destination of an instruction
  // no_dest sits in the top bit, areg below it
  typedef struct packed {
    logic      no_dest;
    arch_reg_t areg;
  } dest_reg_t;

endpackage

// ==== common/rename_defs.svh ====
// Rename subsystem sizes
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Architectural register count
`define RENAME_NREGS 32

// Data word width
`define RENAME_XLEN 32

// Reorder buffer entries
`define RENAME_ROB_DEPTH 16

// ROB index width, log2 of the depth
`define RENAME_ROB_IDX_W 4

`endif
